// File: Bender.yml
package:
  name: nes_cpu_bus

sources:
  # Packages first, then blocks, then the top level
  - design/nes_map_pkg.sv
  - design/nes_dma_pkg.sv
  - design/cpu_bus_decode.sv
  - design/sys_ram.sv
  - design/prg_rom.sv
  - design/joypad_port.sv
  - design/oam_dma.sv
  - design/cpu_read_return.sv
  - design/cpu_bus_top.sv

  # Testbench, top module cpu_bus_tb
  - target: test
    files:
      - sim/cpu_bus_tb.sv

// File: design/cpu_bus_decode.sv
/*
 * CPU access register and address decoder
 * Produces target enables, write payload and read-source tag
 */
`timescale 1ns/1ps

module cpu_bus_decode (
	input  logic                   CPU_CLK,
	input  logic                   reset,
	input  logic                   cpu_valid,
	input  logic                   cpu_rw_n,
	input  nes_map_pkg::cpu_addr_t cpu_addr,
	input  nes_map_pkg::cpu_data_t cpu_wdata,
	input  logic                   dma_busy,
	output logic                   ram_en,
	output logic                   ram_we,
	output nes_map_pkg::ram_addr_t ram_addr,
	output logic                   rom_en,
	output nes_map_pkg::rom_addr_t rom_addr,
	output logic                   pad_we,
	output logic                   pad_re,
	output logic                   dma_start,
	output nes_map_pkg::cpu_data_t dma_page,
	output nes_map_pkg::cpu_data_t wdata_q,
	output logic                   wr_seen,
	output nes_map_pkg::read_src_e rd_src
);
	import nes_map_pkg::*;

	logic      take;
	logic      hit_ram;
	logic      hit_pad;
	logic      hit_dma;
	logic      hit_rom;
	read_src_e rd_next;

	// CPU is halted during DMA, anything it drives is dropped
	assign take = cpu_valid & ~dma_busy;

	// Region compares on the raw address
	assign hit_ram = (cpu_addr <= RAM_END);
	assign hit_pad = (cpu_addr == PAD_ADDR);
	assign hit_dma = (cpu_addr == DMA_ADDR);
	assign hit_rom = (cpu_addr >= ROM_BASE);

	// Tag for the return mux, writes carry no tag
	always_comb begin
		rd_next = RD_NONE;
		if (take && cpu_rw_n) begin
			if (hit_ram)
				rd_next = RD_RAM;
			else if (hit_rom)
				rd_next = RD_ROM;
			else if (hit_pad)
				rd_next = RD_PAD;
		end
	end

	//============================================================
	// Control register
	//============================================================

	always_ff @(posedge CPU_CLK) begin
		if (reset) begin
			ram_en    <= 1'b0;
			ram_we    <= 1'b0;
			rom_en    <= 1'b0;
			pad_we    <= 1'b0;
			pad_re    <= 1'b0;
			dma_start <= 1'b0;
			wr_seen   <= 1'b0;
			rd_src    <= RD_NONE;
		end else begin
			ram_en    <= take & hit_ram;
			ram_we    <= take & hit_ram & ~cpu_rw_n;
			// ROM ignores CPU writes
			rom_en    <= take & hit_rom & cpu_rw_n;
			pad_we    <= take & hit_pad & ~cpu_rw_n;
			pad_re    <= take & hit_pad & cpu_rw_n;
			dma_start <= take & hit_dma & ~cpu_rw_n;
			// Any write drives the data bus
			wr_seen   <= take & ~cpu_rw_n;
			rd_src    <= rd_next;
		end
	end

	// Payload, meaningful only alongside an enable
	always_ff @(posedge CPU_CLK) begin
		if (take) begin
			// Top address bits dropped for the RAM mirror
			ram_addr <= cpu_addr[10:0];
			rom_addr <= cpu_addr[14:0];
			wdata_q  <= cpu_wdata;
		end
		if (take && hit_dma && !cpu_rw_n)
			dma_page <= cpu_wdata;
	end

	//============================================================
	// Checks
	//============================================================

	// A second $4014 write must not land on a running copy
	a_start_idle: assert property (@(posedge CPU_CLK) disable iff (reset)
		dma_start |-> !dma_busy)
		else $error("dma_start raised while DMA busy");

	// CPU must hold off while stalled
	a_stall_drop: assert property (@(posedge CPU_CLK) disable iff (reset)
		dma_busy |-> !cpu_valid)
		else $error("CPU access dropped during DMA stall");

endmodule

// File: design/cpu_bus_top.sv
/*
 * CPU-side memory map top level
 * Decoder, RAM, PRG-ROM, controller, OAM DMA and read return
 */
`timescale 1ns/1ps

module cpu_bus_top (
	input  logic                   CPU_CLK,
	input  logic                   reset,
	input  nes_map_pkg::cpu_addr_t cpu_addr,
	input  nes_map_pkg::cpu_data_t cpu_wdata,
	input  logic                   cpu_rw_n,
	input  logic                   cpu_valid,
	input  logic                   prg_wren,
	input  nes_map_pkg::rom_addr_t prg_addr,
	input  nes_map_pkg::cpu_data_t prg_wdata,
	input  nes_map_pkg::cpu_data_t pad_buttons,
	input  nes_dma_pkg::oam_addr_t oam_raddr,
	output nes_map_pkg::cpu_data_t cpu_rdata,
	output logic                   cpu_stall,
	output nes_map_pkg::cpu_data_t oam_rdata
);
	import nes_map_pkg::*;

	// Decoder outputs
	logic      ram_en, ram_we, rom_en, pad_we, pad_re;
	logic      dma_start, wr_seen;
	ram_addr_t ram_addr;
	rom_addr_t rom_addr;
	cpu_data_t dma_page, wdata_q;
	read_src_e rd_src;

	// Block outputs
	cpu_data_t ram_rdata, rom_rdata, pad_rdata;

	// DMA side of the RAM port
	logic      dma_busy, dma_ram_en;
	ram_addr_t dma_ram_addr;

	// Muxed RAM port
	logic      mux_en, mux_we;
	ram_addr_t mux_addr;

	assign cpu_stall = dma_busy;

	// DMA owns the RAM while it runs, read only
	always_comb begin
		if (dma_busy) begin
			mux_en   = dma_ram_en;
			mux_we   = 1'b0;
			mux_addr = dma_ram_addr;
		end else begin
			mux_en   = ram_en;
			mux_we   = ram_we;
			mux_addr = ram_addr;
		end
	end

	cpu_bus_decode u_decode (
		.CPU_CLK(CPU_CLK), .reset(reset), .cpu_valid(cpu_valid), .cpu_rw_n(cpu_rw_n),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .dma_busy(dma_busy),
		.ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
		.rom_en(rom_en), .rom_addr(rom_addr), .pad_we(pad_we), .pad_re(pad_re),
		.dma_start(dma_start), .dma_page(dma_page), .wdata_q(wdata_q),
		.wr_seen(wr_seen), .rd_src(rd_src)
	);

	sys_ram u_ram (
		.CPU_CLK(CPU_CLK), .en(mux_en), .we(mux_we), .addr(mux_addr),
		.wdata(wdata_q), .rdata(ram_rdata)
	);

	prg_rom u_rom (
		.CPU_CLK(CPU_CLK), .prg_wren(prg_wren), .prg_addr(prg_addr),
		.prg_wdata(prg_wdata), .rd_en(rom_en), .rd_addr(rom_addr), .rdata(rom_rdata)
	);

	joypad_port u_pad (
		.CPU_CLK(CPU_CLK), .reset(reset), .we(pad_we), .re(pad_re),
		.wdata0(wdata_q[0]), .buttons(pad_buttons), .rdata(pad_rdata)
	);

	oam_dma u_dma (
		.CPU_CLK(CPU_CLK), .reset(reset), .dma_start(dma_start), .dma_page(dma_page),
		.ram_rdata(ram_rdata), .oam_raddr(oam_raddr), .dma_busy(dma_busy),
		.dma_ram_en(dma_ram_en), .dma_ram_addr(dma_ram_addr), .oam_rdata(oam_rdata)
	);

	cpu_read_return u_ret (
		.CPU_CLK(CPU_CLK), .reset(reset), .rd_src(rd_src), .wdata_q(wdata_q),
		.wr_seen(wr_seen), .ram_rdata(ram_rdata), .rom_rdata(rom_rdata),
		.pad_rdata(pad_rdata), .cpu_rdata(cpu_rdata)
	);

endmodule

// File: design/cpu_read_return.sv
/*
 * Read-data return mux and open-bus holding register
 */
`timescale 1ns/1ps

module cpu_read_return (
	input  logic                   CPU_CLK,
	input  logic                   reset,
	input  nes_map_pkg::read_src_e rd_src,
	input  nes_map_pkg::cpu_data_t wdata_q,
	input  logic                   wr_seen,
	input  nes_map_pkg::cpu_data_t ram_rdata,
	input  nes_map_pkg::cpu_data_t rom_rdata,
	input  nes_map_pkg::cpu_data_t pad_rdata,
	output nes_map_pkg::cpu_data_t cpu_rdata
);
	import nes_map_pkg::*;

	read_src_e src_q;
	cpu_data_t open_bus;

	// Tag lines up with the memory data here
	always_ff @(posedge CPU_CLK) begin
		if (reset) begin
			src_q    <= RD_NONE;
			open_bus <= '0;
		end else begin
			src_q <= rd_src;
			// A write is younger than the read finishing this cycle
			if (wr_seen)
				open_bus <= wdata_q;
			else if (src_q != RD_NONE)
				open_bus <= cpu_rdata;
		end
	end

	// Unmapped reads see the last value on the bus
	always_comb begin
		case (src_q)
			RD_RAM:  cpu_rdata = ram_rdata;
			RD_ROM:  cpu_rdata = rom_rdata;
			RD_PAD:  cpu_rdata = pad_rdata;
			default: cpu_rdata = open_bus;
		endcase
	end

endmodule

// File: design/joypad_port.sv
/*
 * Controller port at $4016, strobe latch and serial shift register
 */
`timescale 1ns/1ps

module joypad_port (
	input  logic                   CPU_CLK,
	input  logic                   reset,
	input  logic                   we,
	input  logic                   re,
	input  logic                   wdata0,
	input  nes_map_pkg::cpu_data_t buttons,
	output nes_map_pkg::cpu_data_t rdata
);
	import nes_map_pkg::*;

	logic      strobe;
	cpu_data_t shift_q;

	// Strobe and shifter
	always_ff @(posedge CPU_CLK) begin
		if (reset) begin
			strobe  <= 1'b0;
			shift_q <= '0;
		end else begin
			if (we)
				strobe <= wdata0;
			// Strobe high keeps the shifter tracking the live buttons
			if (strobe)
				shift_q <= buttons;
			// Ones fill from the top, reads past eight return 1
			else if (re)
				shift_q <= {1'b1, shift_q[7:1]};
		end
	end

	// Read byte, serial bit in bit 0
	always_ff @(posedge CPU_CLK) begin
		if (re)
			rdata <= {7'b0000000, shift_q[0]};
	end

endmodule

// File: design/nes_dma_pkg.sv
/*
 * Sprite DMA states, transfer length and OAM index type
 */

package nes_dma_pkg;

	// Bytes moved per $4014 write, one RAM page
	localparam int DMA_LEN = 256;

	// Index into sprite memory
	typedef logic [7:0] oam_addr_t;

	// Copy engine states
	// LAST covers the write of the final byte
	typedef enum logic [1:0] {
		DMA_IDLE,
		DMA_COPY,
		DMA_LAST
	} dma_state_e;

endpackage

// File: design/nes_map_pkg.sv
/*
 * CPU address map constants, bus width typedefs
 * and the read-source tag for the return mux
 */

package nes_map_pkg;

	//============================================================
	// Bus widths
	//============================================================

	// Full CPU address
	typedef logic [15:0] cpu_addr_t;

	// One data byte on the CPU bus
	typedef logic [7:0] cpu_data_t;

	// Index into the 2 KiB system RAM
	typedef logic [10:0] ram_addr_t;

	// Index into the 32 KiB PRG-ROM
	typedef logic [14:0] rom_addr_t;

	//============================================================
	// Memory map
	//============================================================

	// System RAM, 2 KiB mirrored four times
	localparam cpu_addr_t RAM_END  = 16'h1FFF;
	localparam int        RAM_DEPTH = 2048;

	// Controller one, strobe on write and serial data on read
	localparam cpu_addr_t PAD_ADDR = 16'h4016;

	// Sprite DMA trigger, write only
	localparam cpu_addr_t DMA_ADDR = 16'h4014;

	// PRG-ROM fills the upper half
	localparam cpu_addr_t ROM_BASE  = 16'h8000;
	localparam int        ROM_DEPTH = 32768;

	//============================================================
	// Read source
	//============================================================

	// Which block answers a read, RD_NONE means open bus
	typedef enum logic [1:0] {
		RD_NONE,
		RD_RAM,
		RD_ROM,
		RD_PAD
	} read_src_e;

endpackage

// File: design/oam_dma.sv
/*
 * OAM DMA page-copy engine
 * 256-byte sprite memory with renderer read port
 */
`timescale 1ns/1ps

module oam_dma (
	input  logic                   CPU_CLK,
	input  logic                   reset,
	input  logic                   dma_start,
	input  nes_map_pkg::cpu_data_t dma_page,
	input  nes_map_pkg::cpu_data_t ram_rdata,
	input  nes_dma_pkg::oam_addr_t oam_raddr,
	output logic                   dma_busy,
	output logic                   dma_ram_en,
	output nes_map_pkg::ram_addr_t dma_ram_addr,
	output nes_map_pkg::cpu_data_t oam_rdata
);
	import nes_map_pkg::*;
	import nes_dma_pkg::*;

	dma_state_e state;
	oam_addr_t  rd_idx;
	oam_addr_t  wr_idx;
	logic [2:0] page_q;
	logic       wr_pend;
	cpu_data_t  oam_mem [DMA_LEN];

	//============================================================
	// Copy FSM
	//============================================================

	always_ff @(posedge CPU_CLK) begin
		if (reset) begin
			state   <= DMA_IDLE;
			rd_idx  <= '0;
			wr_pend <= 1'b0;
		end else begin
			// RAM data lands one cycle after each read
			wr_pend <= (state == DMA_COPY);
			case (state)
				DMA_IDLE: begin
					if (dma_start) begin
						state  <= DMA_COPY;
						rd_idx <= '0;
					end
				end
				DMA_COPY: begin
					rd_idx <= rd_idx + 8'd1;
					if (rd_idx == oam_addr_t'(DMA_LEN - 1))
						state <= DMA_LAST;
				end
				// Final byte written here, stall ends after
				DMA_LAST: state <= DMA_IDLE;
				default:  state <= DMA_IDLE;
			endcase
		end
	end

	// Page and delayed index
	always_ff @(posedge CPU_CLK) begin
		// Only 2 KiB of RAM, page wraps mod 8
		if (dma_start && state == DMA_IDLE)
			page_q <= dma_page[2:0];
		wr_idx <= rd_idx;
	end

	assign dma_busy     = (state != DMA_IDLE);
	assign dma_ram_en   = (state == DMA_COPY);
	assign dma_ram_addr = {page_q, rd_idx};

	//============================================================
	// Sprite memory
	//============================================================

	// Write port fed by DMA, read port for the renderer
	always_ff @(posedge CPU_CLK) begin
		if (wr_pend)
			oam_mem[wr_idx] <= ram_rdata;
		oam_rdata <= oam_mem[oam_raddr];
	end

endmodule

// File: design/prg_rom.sv
/*
 * 32 KiB PRG-ROM with programmer write port and CPU read port
 */
`timescale 1ns/1ps

module prg_rom (
	input  logic                   CPU_CLK,
	input  logic                   prg_wren,
	input  nes_map_pkg::rom_addr_t prg_addr,
	input  nes_map_pkg::cpu_data_t prg_wdata,
	input  logic                   rd_en,
	input  nes_map_pkg::rom_addr_t rd_addr,
	output nes_map_pkg::cpu_data_t rdata
);
	import nes_map_pkg::*;

	cpu_data_t mem [ROM_DEPTH];

	// Loader side, image goes in before the CPU runs
	always_ff @(posedge CPU_CLK) begin
		if (prg_wren)
			mem[prg_addr] <= prg_wdata;
	end

	// CPU side, one cycle latency
	always_ff @(posedge CPU_CLK) begin
		if (rd_en)
			rdata <= mem[rd_addr];
	end

	// Loading and running never overlap
	a_load_vs_fetch: assert property (@(posedge CPU_CLK) !(prg_wren && rd_en))
		else $error("PRG-ROM loaded during CPU read");

endmodule

// File: design/sys_ram.sv
/*
 * 2 KiB single-port system RAM, shared by CPU and DMA
 */
`timescale 1ns/1ps

module sys_ram (
	input  logic                   CPU_CLK,
	input  logic                   en,
	input  logic                   we,
	input  nes_map_pkg::ram_addr_t addr,
	input  nes_map_pkg::cpu_data_t wdata,
	output nes_map_pkg::cpu_data_t rdata
);
	import nes_map_pkg::*;

	cpu_data_t mem [RAM_DEPTH];

	// One port, read registered
	// Read during write returns the old byte
	always_ff @(posedge CPU_CLK) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			rdata <= mem[addr];
		end
	end

endmodule

// File: sim.f
design/nes_map_pkg.sv
design/nes_dma_pkg.sv
design/cpu_bus_decode.sv
design/sys_ram.sv
design/prg_rom.sv
design/joypad_port.sv
design/oam_dma.sv
design/cpu_read_return.sv
design/cpu_bus_top.sv
sim/cpu_bus_tb.sv

// File: sim/cpu_bus_tb.sv
/*
 * Testbench for the CPU-side memory map
 * Table-driven accesses, OAM DMA check, timeout
 */
`timescale 1ns/1ps

module cpu_bus_tb;
	import nes_map_pkg::*;
	import nes_dma_pkg::*;

	typedef enum {OP_WRITE, OP_READ, OP_PROG, OP_DMA} op_e;

	// One table row with the expected read byte in want
	typedef struct {
		op_e         op;
		cpu_addr_t   addr;
		cpu_data_t   data;
		cpu_data_t   want;
		int          test;
	} entry_t;

	logic      CPU_CLK;
	logic      reset;
	cpu_addr_t cpu_addr;
	cpu_data_t cpu_wdata;
	logic      cpu_rw_n;
	logic      cpu_valid;
	logic      prg_wren;
	rom_addr_t prg_addr;
	cpu_data_t prg_wdata;
	cpu_data_t pad_buttons;
	oam_addr_t oam_raddr;
	cpu_data_t cpu_rdata;
	logic      cpu_stall;
	cpu_data_t oam_rdata;

	entry_t      tab [$];
	cpu_data_t   ram_model [2048];
	cpu_data_t   rom_model [32768];
	cpu_data_t   bus_model;
	logic [31:0] rng = 32'ha731_dead;
	int          test_err [7];
	string       test_name [7] = '{"", "reset state", "ram mirror", "prg-rom",
		"controller", "open bus", "oam dma"};
	int          n_pass;
	int          n_fail;
	int          cycles;
	int          limit = 1000000;

	cpu_bus_top DUT (
		.CPU_CLK(CPU_CLK), .reset(reset), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.cpu_rw_n(cpu_rw_n), .cpu_valid(cpu_valid), .prg_wren(prg_wren),
		.prg_addr(prg_addr), .prg_wdata(prg_wdata), .pad_buttons(pad_buttons),
		.oam_raddr(oam_raddr), .cpu_rdata(cpu_rdata), .cpu_stall(cpu_stall),
		.oam_rdata(oam_rdata)
	);

	// 50 MHz CPU clock
	always #10 CPU_CLK = ~CPU_CLK;

	// Run limit from table length plus DMA and readback
	always @(posedge CPU_CLK) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	//============================================================
	// Random data and reference model
	//============================================================

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] rand_word();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic void add_entry(op_e op, cpu_addr_t addr, cpu_data_t data,
		cpu_data_t want, int test);
		entry_t e;
		e.op   = op;
		e.addr = addr;
		e.data = data;
		e.want = want;
		e.test = test;
		tab.push_back(e);
	endfunction

	// Every write drives the data bus
	function automatic void add_write(cpu_addr_t addr, cpu_data_t data, int test);
		if (addr <= RAM_END)
			ram_model[addr[10:0]] = data;
		bus_model = data;
		add_entry(OP_WRITE, addr, data, 8'h00, test);
	endfunction

	// Unmapped reads give back the bus value
	function automatic void add_read(cpu_addr_t addr, int test);
		cpu_data_t want;
		if (addr <= RAM_END)
			want = ram_model[addr[10:0]];
		else if (addr >= ROM_BASE)
			want = rom_model[addr[14:0]];
		else
			want = bus_model;
		bus_model = want;
		add_entry(OP_READ, addr, 8'h00, want, test);
	endfunction

	function automatic void build_table();
		logic [31:0] r;
		cpu_addr_t   a;
		rom_addr_t   prog_addr [16];
		bus_model = 8'h00;
		add_read(16'h5000, 1);
		// RAM write and readback through all four mirrors
		for (int k = 0; k < 16; k++) begin
			r = rand_word();
			a = {5'b00000, r[10:0]};
			add_write(a, r[23:16], 2);
			for (int m = 0; m < 4; m++)
				add_read(a + cpu_addr_t'(m * 16'h0800), 2);
		end
		// Both ROM ends and then random spots
		prog_addr[0] = 15'h0000;
		prog_addr[1] = 15'h7FFF;
		for (int k = 2; k < 16; k++) begin
			r = rand_word();
			prog_addr[k] = r[14:0];
		end
		for (int k = 0; k < 16; k++) begin
			r = rand_word();
			rom_model[prog_addr[k]] = r[7:0];
			add_entry(OP_PROG, {1'b1, prog_addr[k]}, r[7:0], 8'h00, 3);
		end
		for (int k = 0; k < 16; k++)
			add_read({1'b1, prog_addr[k]}, 3);
		// Strobe pulse and serial buttons with bit 0 first
		add_write(PAD_ADDR, 8'h01, 4);
		add_write(PAD_ADDR, 8'h00, 4);
		for (int k = 0; k < 9; k++) begin
			bus_model = (k < 8) ? {7'b0000000, pad_buttons[k]} : 8'h01;
			add_entry(OP_READ, PAD_ADDR, 8'h00, bus_model, 4);
		end
		add_read(16'h2002, 5);
		r = rand_word();
		add_write(16'h6000, r[7:0], 5);
		add_read(16'h6000, 5);
		add_read(ROM_BASE, 5);
		add_read(16'h2002, 5);
		// Page $0B lands on RAM page 3
		for (int k = 0; k < DMA_LEN; k++) begin
			r = rand_word();
			add_write(16'h0B00 + cpu_addr_t'(k), r[7:0], 6);
		end
		bus_model = 8'h0B;
		add_entry(OP_DMA, DMA_ADDR, 8'h0B, 8'h00, 6);
	endfunction

	//============================================================
	// Bus driving and checks
	//============================================================

	task automatic idle_bus();
		cpu_valid <= 1'b0;
		prg_wren  <= 1'b0;
	endtask

	task automatic apply_entry(entry_t e);
		cpu_valid <= (e.op != OP_PROG);
		cpu_rw_n  <= (e.op == OP_READ);
		cpu_addr  <= e.addr;
		cpu_wdata <= e.data;
		prg_wren  <= (e.op == OP_PROG);
		prg_addr  <= e.addr[14:0];
		prg_wdata <= e.data;
	endtask

	task automatic check_byte(string name, cpu_data_t got, cpu_data_t want, int test);
		assert (got === want) else begin
			$display("Error: %s expected %h got %h", name, want, got);
			test_err[test]++;
		end
	endtask

	task automatic report_test(int t);
		if (test_err[t] == 0) begin
			n_pass++;
			$display("test %0d %s: ok", t, test_name[t]);
		end else begin
			n_fail++;
			$display("test %0d %s: failed with %0d errors", t, test_name[t], test_err[t]);
		end
	endtask

	// Read data is due two edges after the access
	task automatic finish_entry(int j);
		if (tab[j].op == OP_READ)
			check_byte($sformatf("cpu_rdata @%h", tab[j].addr), cpu_rdata, tab[j].want,
				tab[j].test);
		if (j == tab.size() - 1 || tab[j + 1].test != tab[j].test)
			report_test(tab[j].test);
	endtask

	// Stall length and sprite memory against the RAM page
	task automatic run_dma(cpu_data_t page, int test);
		int        stall_cycles;
		ram_addr_t idx;
		@(posedge CPU_CLK);
		idle_bus();
		@(negedge CPU_CLK);
		while (!cpu_stall)
			@(negedge CPU_CLK);
		stall_cycles = 0;
		while (cpu_stall) begin
			stall_cycles++;
			@(negedge CPU_CLK);
		end
		assert (stall_cycles == DMA_LEN + 1) else begin
			$display("DMA stalled the CPU for %0d cycles instead of %0d",
				stall_cycles, DMA_LEN + 1);
			test_err[test]++;
		end
		for (int k = 0; k <= DMA_LEN; k++) begin
			@(posedge CPU_CLK);
			if (k < DMA_LEN)
				oam_raddr <= oam_addr_t'(k);
			@(negedge CPU_CLK);
			if (k > 0) begin
				idx = {page[2:0], oam_addr_t'(k - 1)};
				check_byte($sformatf("oam_rdata[%h]", oam_addr_t'(k - 1)), oam_rdata,
					ram_model[idx], test);
			end
		end
	endtask

	//============================================================
	// Main sequence
	//============================================================

	initial begin
		CPU_CLK     = 1'b0;
		reset       = 1'b1;
		cpu_addr    = '0;
		cpu_wdata   = '0;
		cpu_rw_n    = 1'b1;
		cpu_valid   = 1'b0;
		prg_wren    = 1'b0;
		prg_addr    = '0;
		prg_wdata   = '0;
		oam_raddr   = '0;
		pad_buttons = 8'hA5 ^ cpu_data_t'(rand_word());
		build_table();
		limit = 4 * tab.size() + 2 * 265 + 100;

		repeat (10) @(posedge CPU_CLK);
		reset <= 1'b0;
		@(negedge CPU_CLK);
		assert (cpu_stall === 1'b0) else begin
			$display("Error: cpu_stall expected 0 got %h", cpu_stall);
			test_err[1]++;
		end

		// One entry per cycle plus two to drain the pipe
		for (int i = 0; i < tab.size() + 2; i++) begin
			@(posedge CPU_CLK);
			if (i < tab.size())
				apply_entry(tab[i]);
			else
				idle_bus();
			@(negedge CPU_CLK);
			if (i >= 2)
				finish_entry(i - 2);
			if (i < tab.size() && tab[i].op == OP_DMA)
				run_dma(tab[i].data, tab[i].test);
		end

		$display("%0d tests passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
